// ==== dv/tb_dsp_router.sv ====
`timescale 1ns/1ps
/* testbench for the dsp routing core
   random routing, dac mixing, saturation and bus readback
   checked against a local model of the select and mixing rules */
module tb_dsp_router;
   localparam int NS = 8;                        // slots
   localparam int N_ROUTE = 200;
   localparam int N_MIXC = 300;
   localparam int N_RD = 40;
   localparam int N_OPS = 30 + N_ROUTE + N_MIXC + 40 + N_RD + 20;

   logic clk_i, rstn_i, wen_i, ren_i, ack_o, err_o;
   logic [13:0] adc_a_i, adc_b_i, asg_a_i, asg_b_i;
   logic [NS*14-1:0] slot_dat_i, slot_dat_o;
   logic [13:0] dac_a_o, dac_b_o, scope1_o, scope2_o, pwm0_o, pwm1_o;
   logic [NS-1:0] sync_o;
   logic [31:0] addr_i, wdata_i, rdata_o;
   logic [31:0] rd;                              // last read data
   logic [31:0] sync_w;
   logic [3:0] idx, code;
   logic [15:0] offs;
   logic rnd_src;                                // fresh sources with every strobe
   logic [3:0] sh_in [12];                       // shadow source selects
   logic [1:0] sh_out [16];                      // shadow dac selects
   logic [13:0] pipe_a [5];                      // expected dac1 with the oldest at 4
   logic [13:0] pipe_b [5];
   int pend_idx;                                 // out_sel write not yet latched
   logic [1:0] pend_val;

   dsp_router_top #(.NUM_SLOTS(NS)) UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   initial begin
      #(N_OPS * 20 * 4);
      $display("timeout: run did not finish within %0d ns", N_OPS * 20 * 4);
      $display("*** TEST FAILED ***");
      $fatal(1, "watchdog expired");
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // value behind a source code
   function automatic logic [13:0] src_model(input int c);
      case (c)
         8: return asg_a_i;                      // generators
         9: return asg_b_i;
         10: return adc_a_i;
         11: return adc_b_i;
         12: return dac_a_o;                     // registered loop-back
         13: return dac_b_o;
         default: return (c < NS) ? slot_dat_i[c*14 +: 14] : 14'h0;  // 14 unused, 15 none
      endcase
   endfunction

   // gated signed sum of slots and generators with a 14 bit clip
   function automatic logic [13:0] mix_model(input int d);
      int s;
      logic [13:0] v;
      s = 0;
      for (int c = 0; c < 10; c++) begin
         v = (c < NS) ? slot_dat_i[c*14 +: 14] : ((c == 8) ? asg_a_i : asg_b_i);
         if (sh_out[c][d]) s = s + int'($signed(v));
      end
      if (s > 8191) s = 8191;
      else if (s < -8192) s = -8192;
      return 14'(s);
   endfunction

   task automatic rand_sources();
      logic [NS*14-1:0] v;
      for (int n = 0; n < NS; n++) begin
         v[n*14 +: 14] = 14'($urandom);
      end
      slot_dat_i <= v;
      asg_a_i <= 14'($urandom);
      asg_b_i <= 14'($urandom);
      adc_a_i <= 14'($urandom);
      adc_b_i <= 14'($urandom);
   endtask

   // one strobe with ack and data checked one cycle later
   task automatic bus_access(input logic wr, input logic [3:0] i, input logic [15:0] o,
                             input logic [31:0] data);
      @(posedge clk_i);
      addr_i <= {12'h0, i, o};
      wdata_i <= data;
      wen_i <= wr;
      ren_i <= !wr;
      if (rnd_src) rand_sources();
      @(negedge clk_i);
      check_val("ack_o before strobe sampled", ack_o, 0);
      @(posedge clk_i);
      wen_i <= 1'b0;
      ren_i <= 1'b0;
      @(negedge clk_i);
      check_val("ack_o", ack_o, 1);
      check_val("err_o", err_o, 0);
      rd = rdata_o;
   endtask

   task automatic check_routes();
      for (int n = 0; n < NS; n++) begin
         check_val($sformatf("slot_dat_o[%0d]", n), slot_dat_o[n*14 +: 14], src_model(sh_in[n]));
      end
      check_val("scope1_o", scope1_o, src_model(sh_in[8]));
      check_val("scope2_o", scope2_o, src_model(sh_in[9]));
      check_val("pwm0_o", pwm0_o, src_model(sh_in[10]));
      check_val("pwm1_o", pwm1_o, src_model(sh_in[11]));
   endtask

   task automatic set_out(input int i, input logic [1:0] v);
      bus_access(1'b1, 4'(i), 16'h0004, {30'h0, v});
      sh_out[i] = v;
   endtask

   task automatic wait_drain();
      repeat (5) @(posedge clk_i);               // pair, three levels, sum
      @(negedge clk_i);
   endtask

   // new sources and an out_sel write every cycle
   task automatic mix_cycle();
      logic [3:0] i;
      logic [1:0] v;
      i = 4'($urandom);
      v = 2'($urandom);
      @(posedge clk_i);
      rand_sources();
      addr_i <= {12'h0, i, 16'h0004};
      wdata_i <= {30'($urandom), v};
      wen_i <= 1'b1;
      @(negedge clk_i);
      check_val("dac_a_o", dac_a_o, pipe_a[4]);
      check_val("dac_b_o", dac_b_o, pipe_b[4]);
      check_val("pwm0_o", pwm0_o, pipe_a[4]);   // pwm taps on the dac loop-back
      check_val("pwm1_o", pwm1_o, pipe_b[4]);
      if (pend_idx < 10) sh_out[pend_idx] = pend_val;  // latched on this edge
      for (int k = 4; k > 0; k--) begin
         pipe_a[k] = pipe_a[k-1];
         pipe_b[k] = pipe_b[k-1];
      end
      pipe_a[0] = mix_model(0);
      pipe_b[0] = mix_model(1);
      pend_idx = i;
      pend_val = v;
   endtask

   initial begin
      void'($urandom(96));
      rstn_i = 1'b0;
      wen_i = 1'b0;
      ren_i = 1'b0;
      addr_i = '0;
      wdata_i = '0;
      adc_a_i = '0;
      adc_b_i = '0;
      asg_a_i = '0;
      asg_b_i = '0;
      slot_dat_i = '0;
      rnd_src = 1'b1;
      pend_idx = 16;
      for (int k = 0; k < 12; k++) begin
         sh_in[k] = (k == 9) ? 4'd11 : ((k >= 10) ? 4'd15 : 4'd10);  // adc1, adc2, none
      end
      for (int k = 0; k < 16; k++) begin
         sh_out[k] = 2'b00;
      end
      for (int k = 0; k < 5; k++) begin
         pipe_a[k] = '0;                         // tree cleared by reset
         pipe_b[k] = '0;
      end
      repeat (4) @(posedge clk_i);
      rstn_i <= 1'b1;

      // reset values
      for (int k = 0; k < 12; k++) begin
         bus_access(1'b0, 4'(k), 16'h0000, 0);
         check_val($sformatf("rdata_o in_sel[%0d]", k), rd, {28'h0, sh_in[k]});
      end
      for (int k = 0; k < 16; k++) begin
         bus_access(1'b0, 4'(k), 16'h0004, 0);
         check_val($sformatf("rdata_o out_sel[%0d]", k), rd, 0);
      end
      bus_access(1'b0, 4'h0, 16'h000C, 0);
      check_val("rdata_o sync", rd, 32'hFF);
      check_routes();                            // scopes on adcs and pwm taps zero

      // random routing with writes to index 12 and 13 ignored
      for (int n = 0; n < N_ROUTE; n++) begin
         idx = 4'($urandom_range(13, 0));
         code = 4'($urandom);
         bus_access(1'b1, idx, 16'h0000, {28'($urandom), code});
         if (idx < 12) sh_in[idx] = code;
         check_routes();
      end

      // mixing with the pwm taps on dac1 and dac2
      bus_access(1'b1, 4'd10, 16'h0000, 32'd12);
      sh_in[10] = 4'd12;
      bus_access(1'b1, 4'd11, 16'h0000, 32'd13);
      sh_in[11] = 4'd13;
      for (int n = 0; n < N_MIXC; n++) begin
         mix_cycle();
      end
      @(posedge clk_i);
      wen_i <= 1'b0;
      if (pend_idx < 10) sh_out[pend_idx] = pend_val;

      // saturation at positive then negative full scale
      rnd_src = 1'b0;
      @(posedge clk_i);
      slot_dat_i <= {NS{14'h1FFF}};
      asg_a_i <= 14'h1FFF;
      asg_b_i <= 14'h1FFF;
      for (int k = 0; k < 10; k++) begin
         set_out(k, 2'b11);
      end
      wait_drain();
      check_val("dac_a_o", dac_a_o, 14'h1FFF);
      check_val("dac_b_o", dac_b_o, 14'h1FFF);
      bus_access(1'b0, 4'h0, 16'h0008, 0);
      check_val("rdata_o sat", rd, 3);
      @(posedge clk_i);
      slot_dat_i <= {NS{14'h2000}};
      asg_a_i <= 14'h2000;
      asg_b_i <= 14'h2000;
      wait_drain();
      check_val("dac_a_o", dac_a_o, 14'h2000);
      check_val("dac_b_o", dac_b_o, 14'h2000);
      bus_access(1'b0, 4'h0, 16'h0008, 0);
      check_val("rdata_o sat", rd, 3);
      for (int k = 0; k < 10; k++) begin
         set_out(k, 2'b00);
      end
      wait_drain();
      check_val("dac_a_o", dac_a_o, 0);
      check_val("dac_b_o", dac_b_o, 0);
      bus_access(1'b0, 4'h0, 16'h0008, 0);
      check_val("rdata_o sat", rd, 0);

      // readback of live sources, sync mask and unmapped offsets
      rnd_src = 1'b1;
      for (int n = 0; n < N_RD; n++) begin
         code = 4'($urandom);
         bus_access(1'b0, code, 16'h0010, 0);
         check_val($sformatf("rdata_o src_val[%0d]", code), rd, {18'h0, src_model(code)});
      end
      for (int n = 0; n < 5; n++) begin
         sync_w = $urandom;
         bus_access(1'b1, 4'h0, 16'h000C, sync_w);
         check_val("sync_o", sync_o, sync_w[7:0]);
         bus_access(1'b0, 4'h0, 16'h000C, 0);
         check_val("rdata_o sync", rd, {24'h0, sync_w[7:0]});
      end
      for (int n = 0; n < 10; n++) begin
         offs = 16'($urandom) | 16'h0020;        // above the local map
         bus_access(1'b0, 4'($urandom), offs, 0);
         check_val($sformatf("rdata_o offset %h", offs), rd, 0);
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== flist.f ====
verilog/dsp_pkg.sv
verilog/dsp_cfg_regs.sv
verilog/dsp_signal_router.sv
verilog/dsp_dac_mixer.sv
verilog/dsp_router_top.sv
dv/tb_dsp_router.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the dsp router testbench with verilator
# exit status is nonzero when the testbench reports a failure
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -j 0 \
   --top-module tb_dsp_router \
   -f flist.f \
   -o tb_dsp_router
./obj_dir/tb_dsp_router

// ==== verilog/dsp_cfg_regs.sv ====
`timescale 1ns/1ps
/* dsp config registers
   per-sink source selects, per-channel dac selects and slot sync mask,
   with read back of sat flags and live source values */
module dsp_cfg_regs #(
   parameter int NUM_SLOTS = 8
) (
   input  logic clk_i,
   input  logic rstn_i,
   input  logic [31:0] addr_i,
   input  logic [31:0] wdata_i,
   input  logic wen_i,
   input  logic ren_i,
   input  logic [dsp_pkg::NUM_SRC*dsp_pkg::DAT_W-1:0] src_val_i,
   input  logic [1:0] sat_i,
   output logic [dsp_pkg::NUM_SINKS*dsp_pkg::SEL_W-1:0] in_sel_o,
   output logic [dsp_pkg::NUM_MIX*2-1:0] out_sel_o,
   output logic [NUM_SLOTS-1:0] sync_o,
   output logic [31:0] rdata_o,
   output logic ack_o,
   output logic err_o
);
   import dsp_pkg::*;

   localparam int NUM_OUT = SRC_ASG2 + 1;  // slots and both generators

   logic [OFFS_W-1:0] offs;
   logic [SEL_W-1:0] idx;               // slot or sink index
   cfg_word_u wword;
   logic [SEL_W-1:0] in_sel [NUM_SINKS];
   logic [1:0] out_sel [NUM_OUT];
   logic [NUM_SLOTS-1:0] sync;
   logic [31:0] rd_nxt;

   assign offs = addr_i[OFFS_W-1:0];
   assign idx = addr_i[IDX_LSB +: SEL_W];
   assign wword = wdata_i;

   // select and sync registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < NUM_SINKS; k++) begin
            in_sel[k] <= SRC_ADC1;        // slots and scope1 on adc1
         end
         in_sel[SINK_SCOPE2] <= SRC_ADC2;
         in_sel[SINK_PWM0] <= SRC_NONE;   // pwm taps off
         in_sel[SINK_PWM1] <= SRC_NONE;
         for (int k = 0; k < NUM_OUT; k++) begin
            out_sel[k] <= OUT_OFF;
         end
         sync <= '1;                      // all slots running
      end else if (wen_i) begin
         case (offs)
            REG_IN_SEL: begin
               if (idx < NUM_SINKS) begin
                  in_sel[idx] <= wword.in_v.src;
               end
            end
            REG_OUT_SEL: begin
               if (idx < NUM_OUT) begin  // no dac path above generators
                  out_sel[idx] <= wword.out_v.dac;
               end
            end
            REG_SYNC: begin
               sync <= wword.sync_v.mask[NUM_SLOTS-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   // read mux
   always_comb begin
      rd_nxt = '0;                        // unmapped reads as zero
      case (offs)
         REG_IN_SEL: begin
            if (idx < NUM_SINKS) begin
               rd_nxt[SEL_W-1:0] = in_sel[idx];
            end
         end
         REG_OUT_SEL: begin
            if (idx < NUM_OUT) begin
               rd_nxt[1:0] = out_sel[idx];
            end
         end
         REG_SAT: rd_nxt[1:0] = sat_i;    // {dac2, dac1}
         REG_SYNC: rd_nxt[NUM_SLOTS-1:0] = sync;
         REG_SRC_VAL: rd_nxt[DAT_W-1:0] = src_val_i[idx*DAT_W +: DAT_W];  // zero extended
         default: begin
         end
      endcase
   end

   // one cycle ack for every strobe
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= wen_i | ren_i;
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_o <= rd_nxt;
   end

   assign err_o = 1'b0;  // every offset is answered

   // flatten to the datapath
   always_comb begin
      for (int k = 0; k < NUM_SINKS; k++) begin
         in_sel_o[k*SEL_W +: SEL_W] = in_sel[k];
      end
   end

   always_comb begin
      out_sel_o = '0;                     // upper channels never mixed
      for (int k = 0; k < NUM_OUT; k++) begin
         out_sel_o[2*k +: 2] = out_sel[k];
      end
   end

   assign sync_o = sync;

endmodule

// ==== verilog/dsp_dac_mixer.sv ====
`timescale 1ns/1ps
/* dsp dac mixer
   gates each slot and generator channel onto dac1 and dac2, sums them in a
   five stage pairwise adder tree and clips the result to 14 bits */
module dsp_dac_mixer #(
   parameter int NUM_SLOTS = 8
) (
   input  logic clk_i,
   input  logic rstn_i,
   input  logic [NUM_SLOTS*dsp_pkg::DAT_W-1:0] slot_dat_i,
   input  logic [dsp_pkg::DAT_W-1:0] asg_a_i,
   input  logic [dsp_pkg::DAT_W-1:0] asg_b_i,
   input  logic [dsp_pkg::NUM_MIX*2-1:0] out_sel_i,
   output logic [dsp_pkg::DAT_W-1:0] dac_a_o,
   output logic [dsp_pkg::DAT_W-1:0] dac_b_o,
   output logic [1:0] sat_o
);
   import dsp_pkg::*;

   localparam int N_PAIR = NUM_MIX / 2;   // pair stage
   localparam int N_L1 = NUM_MIX / 4;
   localparam int N_L2 = NUM_MIX / 8;
   localparam logic signed [SUM_W-1:0] CLIP_MAX = SUM_W'((1 << (DAT_W - 1)) - 1);
   localparam logic signed [SUM_W-1:0] CLIP_MIN = -SUM_W'(1 << (DAT_W - 1));

   logic signed [SUM_W-1:0] chan [NUM_MIX];
   logic signed [SUM_W-1:0] gated [2][NUM_MIX];   // [dac][channel]
   logic signed [SUM_W-1:0] pair_q [2][N_PAIR];
   logic signed [SUM_W-1:0] l1_q [2][N_L1];
   logic signed [SUM_W-1:0] l2_q [2][N_L2];
   logic signed [SUM_W-1:0] l3_q [2];
   logic signed [SUM_W-1:0] sum_q [2];
   logic [DAT_W-1:0] clip [2];
   logic [1:0] ovf;

   function automatic logic signed [SUM_W-1:0] sext(input logic [DAT_W-1:0] v);
      return {{(SUM_W - DAT_W){v[DAT_W-1]}}, v};
   endfunction

   // channel map matches the source codes
   always_comb begin
      for (int c = 0; c < NUM_MIX; c++) begin
         chan[c] = '0;
      end
      for (int c = 0; c < NUM_SLOTS; c++) begin
         chan[c] = sext(slot_dat_i[c*DAT_W +: DAT_W]);
      end
      chan[SRC_ASG1] = sext(asg_a_i);
      chan[SRC_ASG2] = sext(asg_b_i);
   end

   // per dac enable
   always_comb begin
      for (int c = 0; c < NUM_MIX; c++) begin
         gated[0][c] = |(out_sel_i[2*c +: 2] & OUT_DAC1) ? chan[c] : '0;
         gated[1][c] = |(out_sel_i[2*c +: 2] & OUT_DAC2) ? chan[c] : '0;
      end
   end

   // adder tree, one add per register
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int d = 0; d < 2; d++) begin
            for (int k = 0; k < N_PAIR; k++) begin
               pair_q[d][k] <= '0;
            end
            for (int k = 0; k < N_L1; k++) begin
               l1_q[d][k] <= '0;
            end
            for (int k = 0; k < N_L2; k++) begin
               l2_q[d][k] <= '0;
            end
            l3_q[d] <= '0;
            sum_q[d] <= '0;
         end
      end else begin
         for (int d = 0; d < 2; d++) begin
            for (int k = 0; k < N_PAIR; k++) begin
               pair_q[d][k] <= gated[d][2*k] + gated[d][2*k+1];  // stage 1
            end
            for (int k = 0; k < N_L1; k++) begin
               l1_q[d][k] <= pair_q[d][2*k] + pair_q[d][2*k+1];  // stage 2
            end
            for (int k = 0; k < N_L2; k++) begin
               l2_q[d][k] <= l1_q[d][2*k] + l1_q[d][2*k+1];      // stage 3
            end
            l3_q[d] <= l2_q[d][0] + l2_q[d][1];                  // stage 4
            sum_q[d] <= l3_q[d];                                 // stage 5, timing slack
         end
      end
   end

   // clip to signed 14 bit
   always_comb begin
      for (int d = 0; d < 2; d++) begin
         if (sum_q[d] > CLIP_MAX) begin
            clip[d] = CLIP_MAX[DAT_W-1:0];
            ovf[d] = 1'b1;
         end else if (sum_q[d] < CLIP_MIN) begin
            clip[d] = CLIP_MIN[DAT_W-1:0];
            ovf[d] = 1'b1;
         end else begin
            clip[d] = sum_q[d][DAT_W-1:0];
            ovf[d] = 1'b0;
         end
      end
   end

   assign dac_a_o = clip[0];
   assign dac_b_o = clip[1];
   assign sat_o = ovf;   // bit 0 dac1, bit 1 dac2

endmodule

// ==== verilog/dsp_pkg.sv ====
/* dsp routing package
   sample and select widths, source and sink codes, output selects,
   register map and the bus write word views */
package dsp_pkg;

   localparam int DAT_W = 14;                 // sample width
   localparam int SEL_W = 4;                  // source index width
   localparam int SUM_W = DAT_W + SEL_W;      // adder tree width
   localparam int MAX_SLOTS = 8;              // codes below are laid out for 8 slots
   localparam int NUM_SRC = 1 << SEL_W;       // all source codes, used or not
   localparam int NUM_SINKS = 12;
   localparam int NUM_MIX = 16;               // mixer channels, unused ones at zero

   // source codes, slot n is code n
   localparam logic [SEL_W-1:0] SRC_ASG1 = SEL_W'(MAX_SLOTS);
   localparam logic [SEL_W-1:0] SRC_ASG2 = SEL_W'(MAX_SLOTS + 1);
   localparam logic [SEL_W-1:0] SRC_ADC1 = SEL_W'(MAX_SLOTS + 2);
   localparam logic [SEL_W-1:0] SRC_ADC2 = SEL_W'(MAX_SLOTS + 3);
   localparam logic [SEL_W-1:0] SRC_DAC1 = SEL_W'(MAX_SLOTS + 4);  // dac loop-back
   localparam logic [SEL_W-1:0] SRC_DAC2 = SEL_W'(MAX_SLOTS + 5);
   localparam logic [SEL_W-1:0] SRC_NONE = SEL_W'(NUM_SRC - 1);    // drives zero

   // sink codes, slot n is sink n
   localparam logic [SEL_W-1:0] SINK_SCOPE1 = SEL_W'(8);
   localparam logic [SEL_W-1:0] SINK_SCOPE2 = SEL_W'(9);
   localparam logic [SEL_W-1:0] SINK_PWM0 = SEL_W'(10);
   localparam logic [SEL_W-1:0] SINK_PWM1 = SEL_W'(11);

   // output select, one bit per dac
   localparam logic [1:0] OUT_OFF = 2'b00;
   localparam logic [1:0] OUT_DAC1 = 2'b01;
   localparam logic [1:0] OUT_DAC2 = 2'b10;
   localparam logic [1:0] OUT_BOTH = 2'b11;

   // register map, offset in low 16 bits, index above
   localparam int OFFS_W = 16;
   localparam int IDX_LSB = 16;
   localparam logic [OFFS_W-1:0] REG_IN_SEL = 16'h0000;
   localparam logic [OFFS_W-1:0] REG_OUT_SEL = 16'h0004;
   localparam logic [OFFS_W-1:0] REG_SAT = 16'h0008;
   localparam logic [OFFS_W-1:0] REG_SYNC = 16'h000C;
   localparam logic [OFFS_W-1:0] REG_SRC_VAL = 16'h0010;

   // write word, field picked by the offset
   typedef union packed {
      struct packed {
         logic [31-SEL_W:0] rsvd;
         logic [SEL_W-1:0] src;       // source code
      } in_v;
      struct packed {
         logic [29:0] rsvd;
         logic [1:0] dac;             // dac enables
      } out_v;
      struct packed {
         logic [31-MAX_SLOTS:0] rsvd;
         logic [MAX_SLOTS-1:0] mask;  // one bit per slot
      } sync_v;
   } cfg_word_u;

endpackage

// ==== verilog/dsp_router_top.sv ====
`timescale 1ns/1ps
/* dsp routing and mixing core
   bus config registers, source router and dac mixer for the servo slots */
module dsp_router_top #(
   parameter int NUM_SLOTS = 8
) (
   input  logic clk_i,
   input  logic rstn_i,
   input  logic [dsp_pkg::DAT_W-1:0] adc_a_i,
   input  logic [dsp_pkg::DAT_W-1:0] adc_b_i,
   input  logic [dsp_pkg::DAT_W-1:0] asg_a_i,
   input  logic [dsp_pkg::DAT_W-1:0] asg_b_i,
   input  logic [NUM_SLOTS*dsp_pkg::DAT_W-1:0] slot_dat_i,   // slot outputs
   output logic [NUM_SLOTS*dsp_pkg::DAT_W-1:0] slot_dat_o,   // slot inputs
   output logic [dsp_pkg::DAT_W-1:0] dac_a_o,
   output logic [dsp_pkg::DAT_W-1:0] dac_b_o,
   output logic [dsp_pkg::DAT_W-1:0] scope1_o,
   output logic [dsp_pkg::DAT_W-1:0] scope2_o,
   output logic [dsp_pkg::DAT_W-1:0] pwm0_o,
   output logic [dsp_pkg::DAT_W-1:0] pwm1_o,
   output logic [NUM_SLOTS-1:0] sync_o,
   input  logic [31:0] addr_i,
   input  logic [31:0] wdata_i,
   input  logic wen_i,
   input  logic ren_i,
   output logic [31:0] rdata_o,
   output logic ack_o,
   output logic err_o
);
   import dsp_pkg::*;

   logic [NUM_SINKS*SEL_W-1:0] in_sel;
   logic [NUM_MIX*2-1:0] out_sel;
   logic [NUM_SRC*DAT_W-1:0] src_val;   // router to readback
   logic [1:0] sat;

   dsp_cfg_regs #(
      .NUM_SLOTS (NUM_SLOTS)
   ) u_cfg_regs (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .addr_i    (addr_i),
      .wdata_i   (wdata_i),
      .wen_i     (wen_i),
      .ren_i     (ren_i),
      .src_val_i (src_val),
      .sat_i     (sat),
      .in_sel_o  (in_sel),
      .out_sel_o (out_sel),
      .sync_o    (sync_o),
      .rdata_o   (rdata_o),
      .ack_o     (ack_o),
      .err_o     (err_o)
   );

   dsp_signal_router #(
      .NUM_SLOTS (NUM_SLOTS)
   ) u_router (
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .asg_a_i    (asg_a_i),
      .asg_b_i    (asg_b_i),
      .dac_a_i    (dac_a_o),      // dac loop-back
      .dac_b_i    (dac_b_o),
      .slot_dat_i (slot_dat_i),
      .in_sel_i   (in_sel),
      .slot_dat_o (slot_dat_o),
      .scope1_o   (scope1_o),
      .scope2_o   (scope2_o),
      .pwm0_o     (pwm0_o),
      .pwm1_o     (pwm1_o),
      .src_val_o  (src_val)
   );

   dsp_dac_mixer #(
      .NUM_SLOTS (NUM_SLOTS)
   ) u_mixer (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .slot_dat_i (slot_dat_i),
      .asg_a_i    (asg_a_i),
      .asg_b_i    (asg_b_i),
      .out_sel_i  (out_sel),
      .dac_a_o    (dac_a_o),
      .dac_b_o    (dac_b_o),
      .sat_o      (sat)
   );

endmodule

// ==== verilog/dsp_signal_router.sv ====
`timescale 1ns/1ps
/* dsp source router
   collects slot, adc, generator and dac samples into one source vector
   and drives every sink from its selected source, no registers */
module dsp_signal_router #(
   parameter int NUM_SLOTS = 8
) (
   input  logic [dsp_pkg::DAT_W-1:0] adc_a_i,
   input  logic [dsp_pkg::DAT_W-1:0] adc_b_i,
   input  logic [dsp_pkg::DAT_W-1:0] asg_a_i,
   input  logic [dsp_pkg::DAT_W-1:0] asg_b_i,
   input  logic [dsp_pkg::DAT_W-1:0] dac_a_i,
   input  logic [dsp_pkg::DAT_W-1:0] dac_b_i,
   input  logic [NUM_SLOTS*dsp_pkg::DAT_W-1:0] slot_dat_i,
   input  logic [dsp_pkg::NUM_SINKS*dsp_pkg::SEL_W-1:0] in_sel_i,
   output logic [NUM_SLOTS*dsp_pkg::DAT_W-1:0] slot_dat_o,
   output logic [dsp_pkg::DAT_W-1:0] scope1_o,
   output logic [dsp_pkg::DAT_W-1:0] scope2_o,
   output logic [dsp_pkg::DAT_W-1:0] pwm0_o,
   output logic [dsp_pkg::DAT_W-1:0] pwm1_o,
   output logic [dsp_pkg::NUM_SRC*dsp_pkg::DAT_W-1:0] src_val_o
);
   import dsp_pkg::*;

   logic [DAT_W-1:0] src [NUM_SRC];     // indexed by source code

   // source vector in code order
   always_comb begin
      for (int c = 0; c < NUM_SRC; c++) begin
         src[c] = '0;                     // none and missing slots
      end
      for (int c = 0; c < NUM_SLOTS; c++) begin
         src[c] = slot_dat_i[c*DAT_W +: DAT_W];
      end
      src[SRC_ASG1] = asg_a_i;
      src[SRC_ASG2] = asg_b_i;
      src[SRC_ADC1] = adc_a_i;
      src[SRC_ADC2] = adc_b_i;
      src[SRC_DAC1] = dac_a_i;            // registered in the mixer, no loop
      src[SRC_DAC2] = dac_b_i;
   end

   // slot inputs
   always_comb begin
      for (int n = 0; n < NUM_SLOTS; n++) begin
         slot_dat_o[n*DAT_W +: DAT_W] = src[in_sel_i[n*SEL_W +: SEL_W]];
      end
   end

   // scope and pwm taps
   assign scope1_o = src[in_sel_i[SINK_SCOPE1*SEL_W +: SEL_W]];
   assign scope2_o = src[in_sel_i[SINK_SCOPE2*SEL_W +: SEL_W]];
   assign pwm0_o = src[in_sel_i[SINK_PWM0*SEL_W +: SEL_W]];
   assign pwm1_o = src[in_sel_i[SINK_PWM1*SEL_W +: SEL_W]];

   // live values for bus read back
   always_comb begin
      for (int c = 0; c < NUM_SRC; c++) begin
         src_val_o[c*DAT_W +: DAT_W] = src[c];
      end
   end

endmodule
